// File: list.f
+incdir+test
hdl/mips_pkg.sv
hdl/step_controller.sv
hdl/insn_decoder.sv
hdl/register_file.sv
hdl/decode_execute_stage.sv
hdl/alu_execute.sv
hdl/perf_counter.sv
hdl/mips_core_top.sv
test/tb_mips_core.sv

// File: Makefile
TOP = tb_mips_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: test/tb_mips_model.svh
// decode and alu reference model
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// expected register contents, index zero stays zero
word_t       model_regs [32];
logic [31:0] lcg_state = 32'hdbb1;

// numerical recipes constants
function automatic logic [31:0] rand_word();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// low lcg bits are weak, use the upper ones
function automatic int rand_below(input int n);
	return int'((rand_word() >> 8) % n);
endfunction

// predicted result and destination, returns zero for unsupported words
function automatic bit model_execute(input word_t insn, output word_t result,
		output reg_idx_t dest);
	word_t a;
	word_t b;
	word_t imm_sign;
	word_t imm_zero;
	bit    ok;
	a        = model_regs[insn[25:21]];
	b        = model_regs[insn[20:16]];
	imm_sign = {{16{insn[15]}}, insn[15:0]};
	imm_zero = {16'h0000, insn[15:0]};
	ok       = 1'b1;
	result   = '0;
	// i-type targets rt
	dest     = insn[20:16];
	case (insn[31:26])
		OP_RTYPE:
		begin
			dest = insn[15:11];
			case (insn[5:0])
				FN_ADD:  result = a + b;
				FN_SUB:  result = a - b;
				FN_AND:  result = a & b;
				FN_OR:   result = a | b;
				FN_XOR:  result = a ^ b;
				FN_NOR:  result = ~(a | b);
				FN_SLT:  result = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
				// shifts take rt and shamt
				FN_SLL:  result = b << insn[10:6];
				FN_SRL:  result = b >> insn[10:6];
				default: ok = 1'b0;
			endcase
		end
		OP_ADDI: result = a + imm_sign;
		OP_SLTI: result = ($signed(a) < $signed(imm_sign)) ? word_t'(1) : word_t'(0);
		OP_ANDI: result = a & imm_zero;
		OP_ORI:  result = a | imm_zero;
		OP_XORI: result = a ^ imm_zero;
		OP_LUI:  result = {insn[15:0], 16'h0000};
		default: ok = 1'b0;
	endcase
	return ok;
endfunction

`endif

// File: test/tb_mips_core.sv
// decode and execute slice testbench
`timescale 1ns/1ps

module tb_mips_core;

	import mips_pkg::*;

	// tests take near 2500 cycles, 200 steps of nine dominate
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int N_RANDOM       = 200;

	logic      clock = 1'b0;
	logic      reset;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	word_t     pwdata;
	word_t     prdata;
	logic      pready;
	logic      pslverr;
	int        cycle_count = 0;
	int        issued = 0;

	`include "tb_mips_model.svh"

	mips_core_top dut_i (
		.clock(clock), .reset(reset),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata),
		.prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
	);

	always #20 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_with_failure("run did not finish within the cycle limit");
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
			stop_with_failure($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_count(input string name, input count_t expected, input count_t actual);
		if (expected !== actual)
			stop_with_failure($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic check_err(input string name, input logic expected, input logic actual);
		if (expected !== actual)
			stop_with_failure($sformatf("FAILED %s: expected pslverr %b, actual %b", name, expected, actual));
	endtask

	// entered 2 ns after an edge, leaves at the same offset
	task automatic apb_transfer(input logic write, input apb_addr_t addr, input word_t wdata,
			output word_t rdata, output logic err, output int cycles);
		logic ready_seen;
		ready_seen = 1'b0;
		cycles     = 0;
		psel       = 1'b1;
		penable    = 1'b0;
		pwrite     = write;
		paddr      = addr;
		pwdata     = wdata;
		@(posedge clock);
		#2;
		penable = 1'b1;
		// sample mid cycle, away from the edge
		while (!ready_seen)
		begin
			@(negedge clock);
			cycles++;
			if (pready)
			begin
				ready_seen = 1'b1;
				rdata      = prdata;
				err        = pslverr;
			end
		end
		@(posedge clock);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	function automatic apb_addr_t reg_addr(input reg_idx_t idx);
		return ADDR_REG_BASE | apb_addr_t'({idx, 2'b00});
	endfunction

	task automatic write_reg(input reg_idx_t idx, input word_t data);
		word_t rdata;
		logic  err;
		int    cycles;
		apb_transfer(1'b1, reg_addr(idx), data, rdata, err, cycles);
		check_err($sformatf("write register %0d", idx), 1'b0, err);
		if (idx != 0)
			model_regs[idx] = data;
	endtask

	task automatic read_word(input apb_addr_t addr, output word_t data);
		logic err;
		int   cycles;
		apb_transfer(1'b0, addr, '0, data, err, cycles);
		check_err($sformatf("read at %h", addr), 1'b0, err);
	endtask

	task automatic check_all_regs();
		word_t data;
		for (int i = 0; i < 32; i++)
		begin
			read_word(reg_addr(reg_idx_t'(i)), data);
			check_word($sformatf("register %0d", i), model_regs[i], data);
		end
	endtask

	// one step, then result and destination readback
	task automatic issue_insn(input string name, input word_t insn, output word_t result);
		word_t    expected;
		word_t    rdata;
		reg_idx_t dest;
		logic     err;
		int       cycles;
		bit       ok;
		ok = model_execute(insn, expected, dest);
		if (!ok)
			stop_with_failure($sformatf("%s word %h is not a supported instruction", name, insn));
		apb_transfer(1'b1, ADDR_INSN, insn, rdata, err, cycles);
		check_err(name, 1'b0, err);
		check_count({name, " access cycles"}, count_t'(4), count_t'(cycles));
		if (dest != 0)
			model_regs[dest] = expected;
		issued++;
		read_word(ADDR_RESULT, result);
		check_word({name, " result"}, expected, result);
		read_word(reg_addr(dest), rdata);
		check_word({name, " destination"}, model_regs[dest], rdata);
	endtask

	function automatic word_t random_insn();
		funct_t   fn_list [9] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR,
			FN_SLT, FN_SLL, FN_SRL};
		opcode_t  op_list [6] = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI};
		int       pick;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		shamt_t   sh;
		pick = rand_below(15);
		rs   = reg_idx_t'(rand_below(32));
		rt   = reg_idx_t'(rand_below(32));
		rd   = reg_idx_t'(rand_below(32));
		sh   = shamt_t'(rand_below(32));
		if (pick < 9)
			return {OP_RTYPE, rs, rt, rd, sh, fn_list[pick]};
		return {op_list[pick - 9], rs, rt, 16'(rand_word())};
	endfunction

	initial
	begin
		word_t  data;
		word_t  result;
		count_t before_ret;
		count_t before_busy;
		count_t now_count;
		logic   err;
		int     cycles;
		word_t  expected;
		reg_idx_t dest;
		bit     ok;
		word_t  bad_insns [4];
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		// lw, j, jr and addu sit outside the set
		bad_insns = '{32'h8c22_0004, 32'h0800_0010, 32'h03e0_0008, 32'h0022_1821};
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;

		// everything zero after reset
		check_all_regs();
		read_word(ADDR_RESULT, data);
		check_word("result after reset", '0, data);
		read_word(ADDR_RETIRED, now_count);
		check_count("retired after reset", '0, now_count);
		read_word(ADDR_BUSY, now_count);
		check_count("busy after reset", '0, now_count);

		// random host writes, register zero included
		for (int i = 0; i < 40; i++)
			write_reg(reg_idx_t'(rand_below(32)), rand_word());
		write_reg(5'd0, 32'hffff_ffff);
		check_all_regs();

		for (int i = 0; i < N_RANDOM; i++)
			issue_insn($sformatf("random insn %0d", i), random_insn(), result);

		// immediates with bit 15 set
		write_reg(5'd5, 32'hffff_ffff);
		write_reg(5'd7, 32'h0000_0010);
		issue_insn("andi", {OP_ANDI, 5'd5, 5'd6, 16'h8001}, result);
		check_word("andi zero extend", 32'h0000_8001, result);
		issue_insn("ori", {OP_ORI, 5'd0, 5'd6, 16'h8000}, result);
		check_word("ori zero extend", 32'h0000_8000, result);
		issue_insn("xori", {OP_XORI, 5'd5, 5'd6, 16'h8001}, result);
		check_word("xori zero extend", 32'hffff_7ffe, result);
		issue_insn("addi", {OP_ADDI, 5'd0, 5'd6, 16'h8000}, result);
		check_word("addi sign extend", 32'hffff_8000, result);
		issue_insn("slti", {OP_SLTI, 5'd7, 5'd6, 16'h8000}, result);
		check_word("slti sign extend", 32'h0000_0000, result);

		// rejected words leave registers and counters alone
		foreach (bad_insns[i])
		begin
			ok = model_execute(bad_insns[i], expected, dest);
			if (ok)
				stop_with_failure("invalid instruction list holds a supported word");
			read_word(ADDR_RETIRED, before_ret);
			read_word(ADDR_BUSY, before_busy);
			apb_transfer(1'b1, ADDR_INSN, bad_insns[i], data, err, cycles);
			check_err($sformatf("invalid insn %h", bad_insns[i]), 1'b1, err);
			read_word(ADDR_RETIRED, now_count);
			check_count("retired after invalid insn", before_ret, now_count);
			read_word(ADDR_BUSY, now_count);
			check_count("busy after invalid insn", before_busy, now_count);
			check_all_regs();
		end

		// unmapped read, then an ignored counter write
		apb_transfer(1'b0, 12'h090, '0, data, err, cycles);
		check_err("unmapped read", 1'b1, err);
		check_word("unmapped read data", '0, data);
		apb_transfer(1'b1, ADDR_RETIRED, 32'hdead_beef, data, err, cycles);
		check_err("counter write", 1'b0, err);

		// three busy cycles per step
		read_word(ADDR_RETIRED, now_count);
		check_count("retired count", count_t'(issued), now_count);
		read_word(ADDR_BUSY, now_count);
		check_count("busy count", count_t'(3 * issued), now_count);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: hdl/mips_core_top.sv
// decode and execute slice top
`timescale 1ns/1ps

module mips_core_top
	(
		input  logic                clock,
		input  logic                reset,
		input  logic                psel_i,
		input  logic                penable_i,
		input  logic                pwrite_i,
		input  mips_pkg::apb_addr_t paddr_i,
		input  mips_pkg::word_t     pwdata_i,
		output mips_pkg::word_t     prdata_o,
		output logic                pready_o,
		output logic                pslverr_o
	);

	import mips_pkg::*;

	word_t    insn;
	logic     insn_valid;
	logic     en_pipeline;
	logic     exec_en;
	logic     host_we;
	reg_idx_t host_idx;
	word_t    host_wdata;
	word_t    host_rdata;
	logic     busy_flag;
	count_t   retired_count;
	count_t   busy_count;

	// decoder outputs
	reg_idx_t dec_rs;
	reg_idx_t dec_rt;
	reg_idx_t dec_rd;
	shamt_t   dec_shamt;
	word_t    dec_imm;
	alu_op_t  dec_alu_op;
	logic     dec_use_imm;
	word_t    rf_ra;
	word_t    rf_rb;

	// staged fields
	word_t    st_ra;
	word_t    st_rb;
	word_t    st_imm;
	reg_idx_t st_rd;
	shamt_t   st_shamt;
	alu_op_t  st_alu_op;
	logic     st_use_imm;

	// alu writeback
	word_t    result;
	logic     alu_we;
	reg_idx_t alu_idx;

	// shared write port, host writes only while idle so no overlap
	logic     rf_we;
	reg_idx_t rf_wr_idx;
	word_t    rf_wr_data;

	assign rf_we      = alu_we | host_we;
	assign rf_wr_idx  = alu_we ? alu_idx : host_idx;
	assign rf_wr_data = alu_we ? result : host_wdata;

	step_controller u_ctrl (
		.clock(clock), .reset(reset),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .insn_valid_i(insn_valid),
		.reg_rdata_i(host_rdata), .result_i(result),
		.retired_i(retired_count), .busy_i(busy_count),
		.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
		.insn_o(insn), .en_pipeline_o(en_pipeline), .exec_en_o(exec_en),
		.host_we_o(host_we), .host_idx_o(host_idx), .host_wdata_o(host_wdata),
		.busy_o(busy_flag)
	);

	insn_decoder u_dec (
		.insn_i(insn), .rs_o(dec_rs), .rt_o(dec_rt), .rd_o(dec_rd),
		.shamt_o(dec_shamt), .imm_ext_o(dec_imm), .alu_op_o(dec_alu_op),
		.use_imm_o(dec_use_imm), .valid_o(insn_valid)
	);

	register_file u_rf (
		.clock(clock), .reset(reset),
		.ra_idx_i(dec_rs), .rb_idx_i(dec_rt),
		.wr_en_i(rf_we), .wr_idx_i(rf_wr_idx), .wr_data_i(rf_wr_data),
		.host_idx_i(host_idx),
		.ra_data_o(rf_ra), .rb_data_o(rf_rb), .host_data_o(host_rdata)
	);

	decode_execute_stage u_stage (
		.clock(clock), .reset(reset), .en_pipeline_i(en_pipeline),
		.data_ra_i(rf_ra), .data_rb_i(rf_rb), .imm_ext_i(dec_imm),
		.rd_i(dec_rd), .shamt_i(dec_shamt), .alu_op_i(dec_alu_op),
		.use_imm_i(dec_use_imm),
		.data_ra_o(st_ra), .data_rb_o(st_rb), .imm_ext_o(st_imm),
		.rd_o(st_rd), .shamt_o(st_shamt), .alu_op_o(st_alu_op),
		.use_imm_o(st_use_imm)
	);

	alu_execute u_alu (
		.clock(clock), .reset(reset), .exec_en_i(exec_en),
		.data_ra_i(st_ra), .data_rb_i(st_rb), .imm_ext_i(st_imm),
		.rd_i(st_rd), .shamt_i(st_shamt), .alu_op_i(st_alu_op),
		.use_imm_i(st_use_imm),
		.result_o(result), .wr_en_o(alu_we), .wr_idx_o(alu_idx)
	);

	// retire counts every strobe, register zero included
	perf_counter u_perf (
		.clock(clock), .reset(reset),
		.busy_i(busy_flag), .retire_i(alu_we),
		.retired_o(retired_count), .busy_o(busy_count)
	);

endmodule

// File: hdl/perf_counter.sv
// retired and busy cycle counters
`timescale 1ns/1ps

module perf_counter
	(
		input  logic             clock,
		input  logic             reset,
		input  logic             busy_i,
		input  logic             retire_i,
		output mips_pkg::count_t retired_o,
		output mips_pkg::count_t busy_o
	);

	// both wrap at full width
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			retired_o <= '0;
			busy_o    <= '0;
		end
		else
		begin
			if (retire_i)
				retired_o <= retired_o + 1'b1;
			if (busy_i)
				busy_o <= busy_o + 1'b1;
		end
	end

endmodule

// File: hdl/alu_execute.sv
// execute stage alu
`timescale 1ns/1ps

module alu_execute
	(
		input  logic               clock,
		input  logic               reset,
		input  logic               exec_en_i,
		input  mips_pkg::word_t    data_ra_i,
		input  mips_pkg::word_t    data_rb_i,
		input  mips_pkg::word_t    imm_ext_i,
		input  mips_pkg::reg_idx_t rd_i,
		input  mips_pkg::shamt_t   shamt_i,
		input  mips_pkg::alu_op_t  alu_op_i,
		input  logic               use_imm_i,
		output mips_pkg::word_t    result_o,
		output logic               wr_en_o,
		output mips_pkg::reg_idx_t wr_idx_o
	);

	import mips_pkg::*;

	word_t operand_b;
	word_t alu_value;

	assign operand_b = use_imm_i ? imm_ext_i : data_rb_i;

	// wrapping arithmetic, shifts act on rt
	always_comb
	begin
		case (alu_op_i)
			ALU_ADD: alu_value = data_ra_i + operand_b;
			ALU_SUB: alu_value = data_ra_i - operand_b;
			ALU_AND: alu_value = data_ra_i & operand_b;
			ALU_OR:  alu_value = data_ra_i | operand_b;
			ALU_XOR: alu_value = data_ra_i ^ operand_b;
			ALU_NOR: alu_value = ~(data_ra_i | operand_b);
			ALU_SLT: alu_value = ($signed(data_ra_i) < $signed(operand_b)) ? word_t'(1) : '0;
			ALU_SLL: alu_value = operand_b << shamt_i;
			ALU_SRL: alu_value = operand_b >> shamt_i;
			ALU_LUI: alu_value = {operand_b[15:0], 16'h0000};
			default: alu_value = '0;
		endcase
	end

	// strobe follows the single execute cycle
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			result_o <= '0;
			wr_en_o  <= 1'b0;
			wr_idx_o <= '0;
		end
		else
		begin
			wr_en_o <= exec_en_i;
			if (exec_en_i)
			begin
				result_o <= alu_value;
				wr_idx_o <= rd_i;
			end
		end
	end

	a_strobe_single: assert property (@(posedge clock) disable iff (reset)
		wr_en_o |=> !wr_en_o);

endmodule

// File: hdl/decode_execute_stage.sv
// decode to execute pipeline register
`timescale 1ns/1ps

module decode_execute_stage
	(
		input  logic               clock,
		input  logic               reset,
		input  logic               en_pipeline_i,
		input  mips_pkg::word_t    data_ra_i,
		input  mips_pkg::word_t    data_rb_i,
		input  mips_pkg::word_t    imm_ext_i,
		input  mips_pkg::reg_idx_t rd_i,
		input  mips_pkg::shamt_t   shamt_i,
		input  mips_pkg::alu_op_t  alu_op_i,
		input  logic               use_imm_i,
		output mips_pkg::word_t    data_ra_o,
		output mips_pkg::word_t    data_rb_o,
		output mips_pkg::word_t    imm_ext_o,
		output mips_pkg::reg_idx_t rd_o,
		output mips_pkg::shamt_t   shamt_o,
		output mips_pkg::alu_op_t  alu_op_o,
		output logic               use_imm_o
	);

	import mips_pkg::*;

	// operands and control loaded together, held otherwise
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			data_ra_o <= '0;
			data_rb_o <= '0;
			imm_ext_o <= '0;
			rd_o      <= '0;
			shamt_o   <= '0;
			// add is the zero encoding
			alu_op_o  <= ALU_ADD;
			use_imm_o <= 1'b0;
		end
		else if (en_pipeline_i)
		begin
			data_ra_o <= data_ra_i;
			data_rb_o <= data_rb_i;
			imm_ext_o <= imm_ext_i;
			rd_o      <= rd_i;
			shamt_o   <= shamt_i;
			alu_op_o  <= alu_op_i;
			use_imm_o <= use_imm_i;
		end
	end

endmodule

// File: hdl/register_file.sv
// general purpose register file
`timescale 1ns/1ps

module register_file
	(
		input  logic               clock,
		input  logic               reset,
		input  mips_pkg::reg_idx_t ra_idx_i,
		input  mips_pkg::reg_idx_t rb_idx_i,
		input  logic               wr_en_i,
		input  mips_pkg::reg_idx_t wr_idx_i,
		input  mips_pkg::word_t    wr_data_i,
		input  mips_pkg::reg_idx_t host_idx_i,
		output mips_pkg::word_t    ra_data_o,
		output mips_pkg::word_t    rb_data_o,
		output mips_pkg::word_t    host_data_o
	);

	import mips_pkg::*;

	word_t regs [N_REGS];

	// async reads, register zero hard wired
	assign ra_data_o   = (ra_idx_i == '0) ? '0 : regs[ra_idx_i];
	assign rb_data_o   = (rb_idx_i == '0) ? '0 : regs[rb_idx_i];
	assign host_data_o = (host_idx_i == '0) ? '0 : regs[host_idx_i];

	// cleared so every register reads zero after reset
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < N_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en_i && (wr_idx_i != '0))
			regs[wr_idx_i] <= wr_data_i;
	end

endmodule

// File: hdl/insn_decoder.sv
// instruction field decoder
`timescale 1ns/1ps

module insn_decoder
	(
		input  mips_pkg::word_t    insn_i,
		output mips_pkg::reg_idx_t rs_o,
		output mips_pkg::reg_idx_t rt_o,
		output mips_pkg::reg_idx_t rd_o,
		output mips_pkg::shamt_t   shamt_o,
		output mips_pkg::word_t    imm_ext_o,
		output mips_pkg::alu_op_t  alu_op_o,
		output logic               use_imm_o,
		output logic               valid_o
	);

	import mips_pkg::*;

	opcode_t     opcode;
	funct_t      funct;
	logic [15:0] imm;
	logic        zero_ext;

	// fixed mips field positions
	assign opcode  = insn_i[31:26];
	assign rs_o    = insn_i[25:21];
	assign rt_o    = insn_i[20:16];
	assign shamt_o = insn_i[10:6];
	assign funct   = insn_i[5:0];
	assign imm     = insn_i[15:0];

	// logical immediates are zero extended
	assign imm_ext_o = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	always_comb
	begin
		alu_op_o  = ALU_ADD;
		use_imm_o = 1'b1;
		valid_o   = 1'b1;
		zero_ext  = 1'b0;
		// i-type writes rt
		rd_o      = insn_i[20:16];
		case (opcode)
			OP_RTYPE:
			begin
				use_imm_o = 1'b0;
				rd_o      = insn_i[15:11];
				case (funct)
					FN_ADD:  alu_op_o = ALU_ADD;
					FN_SUB:  alu_op_o = ALU_SUB;
					FN_AND:  alu_op_o = ALU_AND;
					FN_OR:   alu_op_o = ALU_OR;
					FN_XOR:  alu_op_o = ALU_XOR;
					FN_NOR:  alu_op_o = ALU_NOR;
					FN_SLT:  alu_op_o = ALU_SLT;
					FN_SLL:  alu_op_o = ALU_SLL;
					FN_SRL:  alu_op_o = ALU_SRL;
					default: valid_o  = 1'b0;
				endcase
			end
			OP_ADDI: alu_op_o = ALU_ADD;
			OP_SLTI: alu_op_o = ALU_SLT;
			OP_ANDI:
			begin
				alu_op_o = ALU_AND;
				zero_ext = 1'b1;
			end
			OP_ORI:
			begin
				alu_op_o = ALU_OR;
				zero_ext = 1'b1;
			end
			OP_XORI:
			begin
				alu_op_o = ALU_XOR;
				zero_ext = 1'b1;
			end
			OP_LUI:  alu_op_o = ALU_LUI;
			default: valid_o  = 1'b0;
		endcase
	end

endmodule

// File: hdl/step_controller.sv
// apb slave and step sequencer
`timescale 1ns/1ps

module step_controller
	(
		input  logic               clock,
		input  logic               reset,
		input  logic               psel_i,
		input  logic               penable_i,
		input  logic               pwrite_i,
		input  mips_pkg::apb_addr_t paddr_i,
		input  mips_pkg::word_t    pwdata_i,
		input  logic               insn_valid_i,
		input  mips_pkg::word_t    reg_rdata_i,
		input  mips_pkg::word_t    result_i,
		input  mips_pkg::count_t   retired_i,
		input  mips_pkg::count_t   busy_i,
		output mips_pkg::word_t    prdata_o,
		output logic               pready_o,
		output logic               pslverr_o,
		output mips_pkg::word_t    insn_o,
		output logic               en_pipeline_o,
		output logic               exec_en_o,
		output logic               host_we_o,
		output mips_pkg::reg_idx_t host_idx_o,
		output mips_pkg::word_t    host_wdata_o,
		output logic               busy_o
	);

	import mips_pkg::*;

	step_state_t state;
	word_t       insn_reg;
	logic        access;
	logic        idle;
	logic        reg_hit;
	logic        insn_hit;
	logic        addr_hit;
	logic        start;

	// apb access phase
	assign access   = psel_i & penable_i;
	assign idle     = (state == ST_IDLE);
	// word aligned hits inside the register window
	assign reg_hit  = (paddr_i[11:7] == ADDR_REG_BASE[11:7]) && (paddr_i[1:0] == 2'b00);
	assign insn_hit = (paddr_i == ADDR_INSN);
	assign start    = idle & access & pwrite_i & insn_hit & insn_valid_i;

	// decoder sees live write data while idle
	assign insn_o = idle ? pwdata_i : insn_reg;

	// read mux, unmapped reads return zero
	always_comb
	begin
		prdata_o = '0;
		addr_hit = 1'b1;
		if (reg_hit)
			prdata_o = reg_rdata_i;
		else
		begin
			case (paddr_i)
				ADDR_INSN:    prdata_o = insn_reg;
				ADDR_RESULT:  prdata_o = result_i;
				ADDR_RETIRED: prdata_o = retired_i;
				ADDR_BUSY:    prdata_o = busy_i;
				default:      addr_hit = 1'b0;
			endcase
		end
	end

	// no wait states except for a running step
	assign pready_o  = access & ((idle & ~start) | (state == ST_DONE));
	// bad address, or instruction outside the supported set
	assign pslverr_o = access & idle & (~addr_hit | (pwrite_i & insn_hit & ~insn_valid_i));

	// host register writes only while idle
	assign host_we_o    = access & idle & pwrite_i & reg_hit;
	assign host_idx_o   = paddr_i[6:2];
	assign host_wdata_o = pwdata_i;

	assign en_pipeline_o = (state == ST_DECODE);
	assign exec_en_o     = (state == ST_EXECUTE);
	assign busy_o        = ~idle;

	// fixed four cycle step
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state    <= ST_IDLE;
			insn_reg <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						insn_reg <= pwdata_i;
						state    <= ST_DECODE;
					end
				end
				ST_DECODE:  state <= ST_EXECUTE;
				ST_EXECUTE: state <= ST_DONE;
				default:    state <= ST_IDLE;
			endcase
		end
	end

	// pipeline load is followed by execute, never overlapping
	a_enable_order: assert property (@(posedge clock) disable iff (reset)
		en_pipeline_o |-> !exec_en_o ##1 (exec_en_o && !en_pipeline_o));

	a_ready_with_sel: assert property (@(posedge clock) disable iff (reset)
		$rose(pready_o) |-> psel_i);

endmodule

// File: hdl/mips_pkg.sv
// mips slice shared definitions
package mips_pkg;

	// widths
	localparam int DATA_W   = 32;
	localparam int IDX_W    = 5;
	localparam int N_REGS   = 32;
	localparam int COUNT_W  = 32;
	localparam int APB_AW   = 12;

	typedef logic [DATA_W-1:0]  word_t;
	typedef logic [IDX_W-1:0]   reg_idx_t;
	typedef logic [5:0]         opcode_t;
	typedef logic [5:0]         funct_t;
	typedef logic [4:0]         shamt_t;
	typedef logic [3:0]         alu_op_t;
	typedef logic [APB_AW-1:0]  apb_addr_t;
	typedef logic [COUNT_W-1:0] count_t;

	// primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_SLTI  = 6'h0a;
	localparam opcode_t OP_ANDI  = 6'h0c;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_XORI  = 6'h0e;
	localparam opcode_t OP_LUI   = 6'h0f;

	// r-type function codes
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_XOR = 6'h26;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;

	// internal alu operations, zero is add
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_NOR = 4'd5;
	localparam alu_op_t ALU_SLT = 4'd6;
	localparam alu_op_t ALU_SLL = 4'd7;
	localparam alu_op_t ALU_SRL = 4'd8;
	localparam alu_op_t ALU_LUI = 4'd9;

	// apb byte address map, register n at 4*n
	localparam apb_addr_t ADDR_REG_BASE = 12'h000;
	localparam apb_addr_t ADDR_INSN     = 12'h080;
	localparam apb_addr_t ADDR_RESULT   = 12'h084;
	localparam apb_addr_t ADDR_RETIRED  = 12'h088;
	localparam apb_addr_t ADDR_BUSY     = 12'h08c;

	// instruction step sequence
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_EXECUTE,
		ST_DONE
	} step_state_t;

endpackage
